// ==== flist.f ====
+incdir+rtl
rtl/rv_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/mem_unit.sv
rtl/bus_arbiter.sv
rtl/rv_core.sv
tb/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_rv_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module tb_rv_core;

  localparam int          MEM_WORDS    = 1024;
  localparam int          HALT_TIMEOUT = 2000;
  localparam logic [31:0] EBREAK       = 32'h0010_0073;
  localparam logic [31:0] LOOP_LIMIT   = 32'd6;

  logic             clock = 1'b0;
  logic             reset;
  rv_pkg::bus_req_t bus_req_o;
  logic             bus_req_valid_o;
  logic             bus_req_ready_i;
  rv_pkg::bus_rsp_t bus_rsp_i;
  logic             bus_rsp_valid_i;
  logic             halted_o;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] ref_image [MEM_WORDS];
  logic [15:0] lfsr;
  logic        rand_delays;
  int          prog_idx;
  int          errors;
  int          failures;

  rv_core dut (
    .clock           (clock),
    .reset           (reset),
    .bus_req_o       (bus_req_o),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_ready_i (bus_req_ready_i),
    .bus_rsp_i       (bus_rsp_i),
    .bus_rsp_valid_i (bus_rsp_valid_i),
    .halted_o        (halted_o)
  );

  always #10 clock = ~clock;

  // 16-bit Galois LFSR stepped once per bit
  function automatic logic take_bit();
    logic out;
    out  = lfsr[0];
    lfsr = {1'b0, lfsr[15:1]} ^ (out ? 16'hb400 : 16'h0000);
    return out;
  endfunction

  function automatic int pick_delay();
    int d;
    d = 0;
    if (rand_delays) begin
      repeat (2) d = (d << 1) | int'(take_bit());
    end
    return d;
  endfunction

  function automatic logic [31:0] serve(input rv_pkg::bus_req_t req);
    logic [31:0] rdata;
    rdata = '0;
    if (req.addr[31:12] != 20'd0 || req.addr[1:0] != 2'b00) begin
      $display("bus access at %08h is outside the memory or not word aligned", req.addr);
      failures = failures + 1;
    end else if (req.write) begin
      mem[req.addr[11:2]] = req.wdata;
    end else begin
      rdata = mem[req.addr[11:2]];
    end
    return rdata;
  endfunction

  // memory model serving one transaction at a time
  initial begin : mem_model
    rv_pkg::bus_req_t held;
    logic             busy;
    int               accept_wait;
    int               rsp_wait;
    bus_req_ready_i = 1'b0;
    bus_rsp_valid_i = 1'b0;
    bus_rsp_i       = '0;
    held            = '0;
    busy            = 1'b0;
    accept_wait     = 0;
    rsp_wait        = 0;
    forever begin
      @(posedge clock);
      #1;
      bus_req_ready_i = 1'b0;
      bus_rsp_valid_i = 1'b0;
      if (reset) begin
        busy        = 1'b0;
        accept_wait = 0;
      end else if (!busy) begin
        if (bus_req_valid_o) begin
          if (accept_wait == 0) begin
            bus_req_ready_i = 1'b1;
            held            = bus_req_o;
            busy            = 1'b1;
            rsp_wait        = pick_delay();
          end else begin
            accept_wait = accept_wait - 1;
          end
        end
      end else if (rsp_wait == 0) begin
        bus_rsp_i.rdata = serve(held);
        bus_rsp_valid_i = 1'b1;
        busy            = 1'b0;
        accept_wait     = pick_delay();
      end else begin
        rsp_wait = rsp_wait - 1;
      end
    end
  end

  // instruction encoders
  function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3,
                                        input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `RV_OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                        input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            `RV_OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input int imm, input int rd);
    return {imm[19:0], rd[4:0], `RV_OPC_LUI};
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return 32'hc0de_0000 | 32'(idx << 2);
  endfunction

  function automatic logic [31:0] word_at(input int addr);
    return mem[addr[11:2]];
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("** Error: %s = %08h, expected %08h", name, got, exp);
    errors = errors + 1;
  endtask

  task automatic clear_memory();
    int i;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[i[9:0]] = fill_word(i);
    end
    prog_idx = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    mem[prog_idx[9:0]] = word;
    prog_idx = prog_idx + 1;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (5) begin
      @(posedge clock);
      #1;
      if (bus_req_valid_o !== 1'b0) begin
        report_mismatch("bus_req_valid_o", 32'(bus_req_valid_o), 32'h0);
      end
      if (halted_o !== 1'b0) begin
        report_mismatch("halted_o", 32'(halted_o), 32'h0);
      end
    end
    reset = 1'b0;
  endtask

  task automatic wait_halt();
    int cycles;
    cycles = 0;
    while (halted_o !== 1'b1 && cycles < HALT_TIMEOUT) begin
      @(posedge clock);
      #1;
      cycles = cycles + 1;
    end
    if (halted_o !== 1'b1) begin
      $display("timeout: the core did not halt within %0d cycles", HALT_TIMEOUT);
      failures = failures + 1;
    end
  endtask

  task automatic test_reset_state();
    int cycles;
    clear_memory();
    emit(EBREAK);
    apply_reset();
    cycles = 0;
    while (bus_req_valid_o !== 1'b1 && cycles < 20) begin
      @(posedge clock);
      #1;
      cycles = cycles + 1;
    end
    if (bus_req_valid_o !== 1'b1) begin
      $display("no bus request appeared after reset");
      failures = failures + 1;
    end else begin
      // valid stays low while reset drops and rises one cycle later
      if (cycles != 1) begin
        $display("first bus request came %0d cycles after reset dropped instead of 1",
                 cycles);
        failures = failures + 1;
      end
      if (bus_req_o.addr !== `RV_RESET_PC) begin
        report_mismatch("bus_req_o.addr", bus_req_o.addr, `RV_RESET_PC);
      end
      if (bus_req_o.write !== 1'b0) begin
        report_mismatch("bus_req_o.write", 32'(bus_req_o.write), 32'h0);
      end
    end
    wait_halt();
  endtask

  task automatic test_arith();
    logic [31:0] e [1:6];
    int          r;
    e[1] = 32'h1234_5000;
    e[2] = e[1] + 32'hffff_fedd;
    e[3] = e[2] + e[1];
    e[4] = e[1] - e[3];
    e[5] = e[4] & e[3];
    e[6] = e[5] | e[2];
    clear_memory();
    emit(enc_u(32'h12345, 1));
    emit(enc_i(-291, 1, 0, 2, `RV_OPC_OPIMM));
    emit(enc_r(0, 1, 2, 0, 3));
    emit(enc_r(32, 3, 1, 0, 4));
    emit(enc_r(0, 3, 4, 7, 5));
    emit(enc_r(0, 2, 5, 6, 6));
    // x1..x6 to 0x200..0x214
    for (r = 1; r <= 6; r++) begin
      emit(enc_s(32'h1fc + 4 * r, r, 0));
    end
    emit(EBREAK);
    apply_reset();
    wait_halt();
    for (r = 1; r <= 6; r++) begin
      if (word_at(32'h1fc + 4 * r) !== e[r]) begin
        report_mismatch($sformatf("mem[%03h]", 32'h1fc + 4 * r),
                        word_at(32'h1fc + 4 * r), e[r]);
      end
    end
  endtask

  task automatic load_sum_program();
    int k;
    clear_memory();
    mem[192] = 32'h1111_2222;
    mem[193] = 32'h0f0f_0f0f;
    mem[194] = 32'h8000_0001;
    emit(enc_i(0, 0, 0, 10, `RV_OPC_OPIMM));
    // each loaded word is used by the very next instruction
    for (k = 0; k < 3; k++) begin
      emit(enc_i(32'h300 + 4 * k, 0, 2, k + 1, `RV_OPC_LOAD));
      emit(enc_r(0, k + 1, 10, 0, 10));
    end
    emit(enc_s(32'h30c, 10, 0));
    emit(EBREAK);
  endtask

  task automatic test_loads();
    logic [31:0] sum;
    sum = 32'h1111_2222 + 32'h0f0f_0f0f + 32'h8000_0001;
    load_sum_program();
    apply_reset();
    wait_halt();
    if (word_at(32'h30c) !== sum) begin
      report_mismatch("mem[30c]", word_at(32'h30c), sum);
    end
    ref_image = mem;
  endtask

  task automatic test_branches();
    clear_memory();
    emit(enc_i(0, 0, 0, 1, `RV_OPC_OPIMM));
    emit(enc_i(LOOP_LIMIT, 0, 0, 2, `RV_OPC_OPIMM));
    emit(enc_i(1, 1, 0, 1, `RV_OPC_OPIMM));
    emit(enc_b(-4, 2, 1, 1));
    // beq falls through and the second bne jumps over the store to 0x404
    emit(enc_b(12, 0, 1, 0));
    emit(enc_s(32'h400, 1, 0));
    emit(enc_b(8, 0, 1, 1));
    emit(enc_s(32'h404, 2, 0));
    emit(EBREAK);
    apply_reset();
    wait_halt();
    if (word_at(32'h400) !== LOOP_LIMIT) begin
      report_mismatch("mem[400]", word_at(32'h400), LOOP_LIMIT);
    end
    if (word_at(32'h404) !== fill_word(257)) begin
      report_mismatch("mem[404]", word_at(32'h404), fill_word(257));
    end
  endtask

  task automatic test_backpressure();
    int  i;
    int  c;
    logic seen;
    rand_delays = 1'b1;
    load_sum_program();
    apply_reset();
    wait_halt();
    for (i = 0; i < MEM_WORDS; i++) begin
      if (mem[i[9:0]] !== ref_image[i[9:0]]) begin
        report_mismatch($sformatf("mem[%03h]", i * 4), mem[i[9:0]], ref_image[i[9:0]]);
      end
    end
    seen = 1'b0;
    for (c = 1; c <= 50; c++) begin
      @(posedge clock);
      #1;
      if (bus_req_valid_o !== 1'b0 && !seen) begin
        $display("bus request raised %0d cycles after the core halted", c);
        failures = failures + 1;
        seen     = 1'b1;
      end
    end
    rand_delays = 1'b0;
  endtask

  initial begin
    reset       = 1'b1;
    rand_delays = 1'b0;
    lfsr        = 16'd5728;
    prog_idx    = 0;
    errors      = 0;
    failures    = 0;
    test_reset_state();
    test_arith();
    test_loads();
    test_branches();
    test_backpressure();
    $display("value errors: %0d, other failures: %0d", errors, failures);
    if (errors == 0 && failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic             clock,
  input  logic             reset,
  output rv_pkg::bus_req_t bus_req_o,
  output logic             bus_req_valid_o,
  input  logic             bus_req_ready_i,
  input  rv_pkg::bus_rsp_t bus_rsp_i,
  input  logic             bus_rsp_valid_i,
  output logic             halted_o
);

  logic               redirect_valid;
  rv_pkg::word_t      redirect_pc;
  rv_pkg::fetch_pkt_t fetch_pkt;
  logic               fetch_valid;
  logic               fetch_ready;
  rv_pkg::bus_req_t   ireq;
  logic               ireq_valid;
  logic               ireq_ready;
  rv_pkg::bus_rsp_t   irsp;
  logic               irsp_valid;
  rv_pkg::reg_addr_t  rs1_addr;
  rv_pkg::reg_addr_t  rs2_addr;
  rv_pkg::word_t      rs1_data;
  rv_pkg::word_t      rs2_data;
  logic               ex_pend_valid;
  rv_pkg::reg_addr_t  ex_pend_rd;
  logic               mem_pend_valid;
  rv_pkg::reg_addr_t  mem_pend_rd;
  rv_pkg::exec_pkt_t  exec_pkt;
  logic               exec_valid;
  logic               exec_ready;
  rv_pkg::mem_pkt_t   mem_pkt;
  logic               mem_valid;
  logic               mem_ready;
  rv_pkg::bus_req_t   dreq;
  logic               dreq_valid;
  logic               dreq_ready;
  rv_pkg::bus_rsp_t   drsp;
  logic               drsp_valid;
  rv_pkg::wb_t        wb;

  fetch_unit u_fetch (
    .clock            (clock),
    .reset            (reset),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .halt_i           (halted_o),
    .fetch_o          (fetch_pkt),
    .fetch_valid_o    (fetch_valid),
    .fetch_ready_i    (fetch_ready),
    .ireq_o           (ireq),
    .ireq_valid_o     (ireq_valid),
    .ireq_ready_i     (ireq_ready),
    .irsp_i           (irsp),
    .irsp_valid_i     (irsp_valid)
  );

  decode_unit u_decode (
    .clock            (clock),
    .reset            (reset),
    .fetch_i          (fetch_pkt),
    .fetch_valid_i    (fetch_valid),
    .fetch_ready_o    (fetch_ready),
    .rs1_addr_o       (rs1_addr),
    .rs2_addr_o       (rs2_addr),
    .rs1_data_i       (rs1_data),
    .rs2_data_i       (rs2_data),
    .ex_pend_valid_i  (ex_pend_valid),
    .ex_pend_rd_i     (ex_pend_rd),
    .mem_pend_valid_i (mem_pend_valid),
    .mem_pend_rd_i    (mem_pend_rd),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc),
    .exec_o           (exec_pkt),
    .exec_valid_o     (exec_valid),
    .exec_ready_i     (exec_ready)
  );

  reg_file u_regs (
    .clock      (clock),
    .reset      (reset),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (wb)
  );

  execute_unit u_exec (
    .clock        (clock),
    .reset        (reset),
    .exec_i       (exec_pkt),
    .exec_valid_i (exec_valid),
    .exec_ready_o (exec_ready),
    .pend_valid_o (ex_pend_valid),
    .pend_rd_o    (ex_pend_rd),
    .mem_o        (mem_pkt),
    .mem_valid_o  (mem_valid),
    .mem_ready_i  (mem_ready)
  );

  mem_unit u_mem (
    .clock        (clock),
    .reset        (reset),
    .mem_i        (mem_pkt),
    .mem_valid_i  (mem_valid),
    .mem_ready_o  (mem_ready),
    .pend_valid_o (mem_pend_valid),
    .pend_rd_o    (mem_pend_rd),
    .dreq_o       (dreq),
    .dreq_valid_o (dreq_valid),
    .dreq_ready_i (dreq_ready),
    .drsp_i       (drsp),
    .drsp_valid_i (drsp_valid),
    .wb_o         (wb),
    .halted_o     (halted_o)
  );

  bus_arbiter u_arb (
    .clock           (clock),
    .reset           (reset),
    .ireq_i          (ireq),
    .ireq_valid_i    (ireq_valid),
    .ireq_ready_o    (ireq_ready),
    .irsp_o          (irsp),
    .irsp_valid_o    (irsp_valid),
    .dreq_i          (dreq),
    .dreq_valid_i    (dreq_valid),
    .dreq_ready_o    (dreq_ready),
    .drsp_o          (drsp),
    .drsp_valid_o    (drsp_valid),
    .bus_req_o       (bus_req_o),
    .bus_req_valid_o (bus_req_valid_o),
    .bus_req_ready_i (bus_req_ready_i),
    .bus_rsp_i       (bus_rsp_i),
    .bus_rsp_valid_i (bus_rsp_valid_i)
  );

endmodule

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
  input  logic             clock,
  input  logic             reset,
  input  rv_pkg::bus_req_t ireq_i,
  input  logic             ireq_valid_i,
  output logic             ireq_ready_o,
  output rv_pkg::bus_rsp_t irsp_o,
  output logic             irsp_valid_o,
  input  rv_pkg::bus_req_t dreq_i,
  input  logic             dreq_valid_i,
  output logic             dreq_ready_o,
  output rv_pkg::bus_rsp_t drsp_o,
  output logic             drsp_valid_o,
  output rv_pkg::bus_req_t bus_req_o,
  output logic             bus_req_valid_o,
  input  logic             bus_req_ready_i,
  input  rv_pkg::bus_rsp_t bus_rsp_i,
  input  logic             bus_rsp_valid_i
);

  // HOLD keeps a grant that the port has not yet accepted
  typedef enum logic [1:0] {ARB_IDLE, ARB_HOLD, ARB_WAIT} state_e;

  state_e state;
  logic   data_owner;
  logic   sel_data;

  // data side wins a fresh grant
  assign sel_data = (state == ARB_HOLD) ? data_owner : dreq_valid_i;

  assign bus_req_valid_o = (state == ARB_HOLD) ||
                           (state == ARB_IDLE && (dreq_valid_i || ireq_valid_i));
  assign bus_req_o       = sel_data ? dreq_i : ireq_i;

  assign dreq_ready_o = bus_req_valid_o && bus_req_ready_i && sel_data;
  assign ireq_ready_o = bus_req_valid_o && bus_req_ready_i && !sel_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= ARB_IDLE;
      data_owner <= 1'b0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (bus_req_valid_o) begin
            data_owner <= sel_data;
            state      <= bus_req_ready_i ? ARB_WAIT : ARB_HOLD;
          end
        end
        ARB_HOLD: if (bus_req_ready_i) state <= ARB_WAIT;
        ARB_WAIT: if (bus_rsp_valid_i) state <= ARB_IDLE;
        default:  state <= ARB_IDLE;
      endcase
    end
  end

  // response goes only to the owner of the outstanding request
  assign irsp_o       = bus_rsp_i;
  assign drsp_o       = bus_rsp_i;
  assign irsp_valid_o = bus_rsp_valid_i && (state == ARB_WAIT) && !data_owner;
  assign drsp_valid_o = bus_rsp_valid_i && (state == ARB_WAIT) && data_owner;

endmodule

// ==== rtl/mem_unit.sv ====
`timescale 1ns/1ps

module mem_unit (
  input  logic              clock,
  input  logic              reset,
  input  rv_pkg::mem_pkt_t  mem_i,
  input  logic              mem_valid_i,
  output logic              mem_ready_o,
  output logic              pend_valid_o,
  output rv_pkg::reg_addr_t pend_rd_o,
  output rv_pkg::bus_req_t  dreq_o,
  output logic              dreq_valid_o,
  input  logic              dreq_ready_i,
  input  rv_pkg::bus_rsp_t  drsp_i,
  input  logic              drsp_valid_i,
  output rv_pkg::wb_t       wb_o,
  output logic              halted_o
);

  rv_pkg::mem_pkt_t cur;
  logic             valid;
  logic             issued;
  logic             is_mem;
  logic             done;
  logic             take;

  assign is_mem = (cur.mem_op != rv_pkg::MEM_NONE);
  // ALU results retire at once, bus accesses on their response
  assign done        = valid && (!is_mem || drsp_valid_i);
  assign mem_ready_o = !valid || done;
  assign take        = mem_valid_i && mem_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      valid    <= 1'b0;
      issued   <= 1'b0;
      halted_o <= 1'b0;
    end else begin
      if (take) valid <= 1'b1;
      else if (done) valid <= 1'b0;
      if (dreq_valid_o && dreq_ready_i) issued <= 1'b1;
      else if (done) issued <= 1'b0;
      if (take && mem_i.halt) halted_o <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (take) cur <= mem_i;
  end

  assign dreq_valid_o = valid && is_mem && !issued;
  assign dreq_o.addr  = cur.result;
  assign dreq_o.wdata = cur.store_data;
  assign dreq_o.write = (cur.mem_op == rv_pkg::MEM_STORE);

  assign wb_o.en   = done && cur.rd_we;
  assign wb_o.rd   = cur.rd;
  assign wb_o.data = (cur.mem_op == rv_pkg::MEM_LOAD) ? drsp_i.rdata : cur.result;

  assign pend_valid_o = valid && cur.rd_we;
  assign pend_rd_o    = cur.rd;

endmodule

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
  input  logic              clock,
  input  logic              reset,
  input  rv_pkg::exec_pkt_t exec_i,
  input  logic              exec_valid_i,
  output logic              exec_ready_o,
  output logic              pend_valid_o,
  output rv_pkg::reg_addr_t pend_rd_o,
  output rv_pkg::mem_pkt_t  mem_o,
  output logic              mem_valid_o,
  input  logic              mem_ready_i
);

  rv_pkg::word_t result;
  logic          take;

  always_comb begin
    case (exec_i.alu_op)
      rv_pkg::ALU_SUB:   result = exec_i.op_a - exec_i.op_b;
      rv_pkg::ALU_AND:   result = exec_i.op_a & exec_i.op_b;
      rv_pkg::ALU_OR:    result = exec_i.op_a | exec_i.op_b;
      rv_pkg::ALU_PASSB: result = exec_i.op_b;
      default:           result = exec_i.op_a + exec_i.op_b;
    endcase
  end

  assign exec_ready_o = !mem_valid_o || mem_ready_i;
  assign take         = exec_valid_i && exec_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid_o <= 1'b0;
    end else if (take) begin
      mem_valid_o <= 1'b1;
    end else if (mem_ready_i) begin
      mem_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      mem_o.result     <= result;
      mem_o.store_data <= exec_i.store_data;
      mem_o.mem_op     <= exec_i.mem_op;
      mem_o.rd         <= exec_i.rd;
      mem_o.rd_we      <= exec_i.rd_we;
      mem_o.halt       <= exec_i.halt;
    end
  end

  assign pend_valid_o = mem_valid_o && mem_o.rd_we;
  assign pend_rd_o    = mem_o.rd;

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module reg_file (
  input  logic              clock,
  input  logic              reset,
  input  rv_pkg::reg_addr_t rs1_addr_i,
  input  rv_pkg::reg_addr_t rs2_addr_i,
  output rv_pkg::word_t     rs1_data_o,
  output rv_pkg::word_t     rs2_data_o,
  input  rv_pkg::wb_t       wb_i
);

  rv_pkg::word_t regs [`RV_NUM_REGS];

  // no writeback lands while the core is held in reset
  always_ff @(posedge clock) begin
    if (!reset && wb_i.en && wb_i.rd != '0) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  // x0 reads as zero
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== rtl/decode_unit.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module decode_unit (
  input  logic               clock,
  input  logic               reset,
  input  rv_pkg::fetch_pkt_t fetch_i,
  input  logic               fetch_valid_i,
  output logic               fetch_ready_o,
  output rv_pkg::reg_addr_t  rs1_addr_o,
  output rv_pkg::reg_addr_t  rs2_addr_o,
  input  rv_pkg::word_t      rs1_data_i,
  input  rv_pkg::word_t      rs2_data_i,
  input  logic               ex_pend_valid_i,
  input  rv_pkg::reg_addr_t  ex_pend_rd_i,
  input  logic               mem_pend_valid_i,
  input  rv_pkg::reg_addr_t  mem_pend_rd_i,
  output logic               redirect_valid_o,
  output rv_pkg::word_t      redirect_pc_o,
  output rv_pkg::exec_pkt_t  exec_o,
  output logic               exec_valid_o,
  input  logic               exec_ready_i
);

  rv_pkg::fetch_pkt_t cur;
  logic               cur_valid;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  rv_pkg::word_t      imm_i;
  rv_pkg::word_t      imm_s;
  rv_pkg::word_t      imm_b;
  rv_pkg::word_t      imm_u;
  rv_pkg::exec_pkt_t  pkt;
  logic               is_branch;
  logic               taken;
  logic               stall;
  logic               fire;

  // rd still in flight downstream, including our own output register
  function automatic logic pend_hit(input rv_pkg::reg_addr_t rs);
    pend_hit = (rs != '0) &&
               ((ex_pend_valid_i && ex_pend_rd_i == rs) ||
                (mem_pend_valid_i && mem_pend_rd_i == rs) ||
                (exec_valid_o && exec_o.rd_we && exec_o.rd == rs));
  endfunction

  assign opcode     = cur.instr[6:0];
  assign funct3     = cur.instr[14:12];
  assign rs1_addr_o = cur.instr[19:15];
  assign rs2_addr_o = cur.instr[24:20];

  assign imm_i = {{20{cur.instr[31]}}, cur.instr[31:20]};
  assign imm_s = {{20{cur.instr[31]}}, cur.instr[31:25], cur.instr[11:7]};
  assign imm_b = {{19{cur.instr[31]}}, cur.instr[31], cur.instr[7],
                  cur.instr[30:25], cur.instr[11:8], 1'b0};
  assign imm_u = {cur.instr[31:12], 12'b0};

  always_comb begin
    pkt            = '0;
    pkt.op_a       = rs1_data_i;
    pkt.op_b       = rs2_data_i;
    pkt.store_data = rs2_data_i;
    pkt.alu_op     = rv_pkg::ALU_ADD;
    pkt.mem_op     = rv_pkg::MEM_NONE;
    pkt.rd         = cur.instr[11:7];
    is_branch      = 1'b0;
    case (opcode)
      `RV_OPC_OP: begin
        pkt.rd_we = 1'b1;
        if (funct3 == 3'b111) pkt.alu_op = rv_pkg::ALU_AND;
        else if (funct3 == 3'b110) pkt.alu_op = rv_pkg::ALU_OR;
        else if (cur.instr[30]) pkt.alu_op = rv_pkg::ALU_SUB;
      end
      `RV_OPC_OPIMM: begin
        pkt.op_b  = imm_i;
        pkt.rd_we = 1'b1;
      end
      `RV_OPC_LUI: begin
        pkt.op_b   = imm_u;
        pkt.alu_op = rv_pkg::ALU_PASSB;
        pkt.rd_we  = 1'b1;
      end
      `RV_OPC_LOAD: begin
        pkt.op_b   = imm_i;
        pkt.mem_op = rv_pkg::MEM_LOAD;
        pkt.rd_we  = 1'b1;
      end
      `RV_OPC_STORE: begin
        pkt.op_b   = imm_s;
        pkt.mem_op = rv_pkg::MEM_STORE;
      end
      `RV_OPC_BRANCH: is_branch = 1'b1;
      `RV_OPC_SYSTEM: pkt.halt = 1'b1;
      default: ;
    endcase
    if (pkt.rd == '0) pkt.rd_we = 1'b0;
  end

  // funct3[0] picks BNE over BEQ
  assign taken = is_branch && ((rs1_data_i == rs2_data_i) ^ funct3[0]);

  assign stall = pend_hit(rs1_addr_o) || pend_hit(rs2_addr_o);
  assign fire  = cur_valid && !stall && (!exec_valid_o || exec_ready_i);

  assign fetch_ready_o    = !cur_valid;
  assign redirect_valid_o = fire && !pkt.halt;
  assign redirect_pc_o    = taken ? cur.pc + imm_b : cur.pc + 32'd4;

  always_ff @(posedge clock) begin
    if (reset) begin
      cur_valid    <= 1'b0;
      exec_valid_o <= 1'b0;
    end else begin
      if (fetch_valid_i && fetch_ready_o) cur_valid <= 1'b1;
      else if (fire) cur_valid <= 1'b0;
      if (fire) exec_valid_o <= 1'b1;
      else if (exec_ready_i) exec_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_valid_i && fetch_ready_o) cur <= fetch_i;
    if (fire) exec_o <= pkt;
  end

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`include "rv_cfg.svh"

module fetch_unit (
  input  logic               clock,
  input  logic               reset,
  input  logic               redirect_valid_i,
  input  rv_pkg::word_t      redirect_pc_i,
  input  logic               halt_i,
  output rv_pkg::fetch_pkt_t fetch_o,
  output logic               fetch_valid_o,
  input  logic               fetch_ready_i,
  output rv_pkg::bus_req_t   ireq_o,
  output logic               ireq_valid_o,
  input  logic               ireq_ready_i,
  input  rv_pkg::bus_rsp_t   irsp_i,
  input  logic               irsp_valid_i
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT, HOLD} state_e;

  state_e        state;
  logic          boot;
  rv_pkg::word_t pc;
  rv_pkg::word_t instr;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
      boot  <= 1'b1;
      pc    <= `RV_RESET_PC;
    end else begin
      case (state)
        // leave idle once after reset, then only on a redirect
        IDLE: begin
          if (boot) begin
            boot  <= 1'b0;
            state <= REQ;
          end else if (redirect_valid_i && !halt_i) begin
            pc    <= redirect_pc_i;
            state <= REQ;
          end
        end
        REQ:  if (ireq_ready_i) state <= WAIT;
        WAIT: if (irsp_valid_i) state <= HOLD;
        HOLD: if (fetch_ready_i) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == WAIT && irsp_valid_i) begin
      instr <= irsp_i.rdata;
    end
  end

  assign ireq_valid_o  = (state == REQ);
  assign ireq_o.addr   = pc;
  assign ireq_o.wdata  = '0;
  assign ireq_o.write  = 1'b0;

  assign fetch_valid_o = (state == HOLD);
  assign fetch_o.pc    = pc;
  assign fetch_o.instr = instr;

endmodule

// ==== rtl/rv_pkg.sv ====
`include "rv_cfg.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

  // ALU_PASSB forwards operand b, used by LUI
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_PASSB
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } fetch_pkt_t;

  typedef struct packed {
    word_t     op_a;
    word_t     op_b;
    word_t     store_data;
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    reg_addr_t rd;
    logic      rd_we;
    logic      halt;
  } exec_pkt_t;

  // result doubles as the address for loads and stores
  typedef struct packed {
    word_t     result;
    word_t     store_data;
    mem_op_e   mem_op;
    reg_addr_t rd;
    logic      rd_we;
    logic      halt;
  } mem_pkt_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  write;
  } bus_req_t;

  typedef struct packed {
    word_t rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic      en;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

endpackage

// ==== rtl/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// first fetch address after reset
`define RV_RESET_PC   32'h0000_0000

`define RV_XLEN       32
`define RV_NUM_REGS   32

// major opcodes, instr[6:0]
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OPIMM  7'b0010011
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_SYSTEM 7'b1110011

`endif
